// ==== all.f ====
hw/lcd_pkg.sv
hw/lcd_pixel_fifo.sv
hw/lcd_cmd_engine.sv
hw/lcd_pixel_writer.sv
hw/lcd_bus_port.sv
hw/lcd_ctrl_top.sv
bench/lcd_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: lcd_ctrl

sources:
  - hw/lcd_pkg.sv
  - hw/lcd_pixel_fifo.sv
  - hw/lcd_cmd_engine.sv
  - hw/lcd_pixel_writer.sv
  - hw/lcd_bus_port.sv
  - hw/lcd_ctrl_top.sv
  - target: simulation
    files:
      - bench/lcd_ctrl_tb.sv

// ==== bench/lcd_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_tb;
  import lcd_pkg::*;

  localparam int          HALF_PERIOD = 2;
  localparam int          TIMEOUT     = 200;
  localparam int          QUIET       = 20;
  localparam int          GAP         = 9;
  localparam int          NUM_ROWS    = 10;
  localparam logic [31:0] SEED        = 32'hf1a7301d;

  typedef enum logic [2:0] {OP_CMD, OP_PARAM, OP_READ, OP_FRAME, OP_FRAME_GAP} op_e;

  typedef struct packed {
    op_e       op;
    lcd_byte_t value;
    logic [4:0] count;
    logic      tearing;
  } row_t;

  // Byte seen on the pads during one write strobe
  typedef struct packed {
    logic      dc;
    lcd_byte_t data;
  } bus_byte_t;

  // Operation, command byte, pixel count, tearing wait
  localparam row_t ROWS [NUM_ROWS] = '{
    '{OP_CMD,       8'h11, 5'd0, 1'b0},
    '{OP_PARAM,     8'hA5, 5'd0, 1'b0},
    '{OP_READ,      8'h00, 5'd0, 1'b0},
    '{OP_CMD,       8'h3A, 5'd0, 1'b0},
    '{OP_PARAM,     8'h55, 5'd0, 1'b0},
    '{OP_FRAME,     8'h00, 5'd3, 1'b0},
    '{OP_FRAME,     8'h00, 5'd2, 1'b1},
    '{OP_FRAME_GAP, 8'h00, 5'd4, 1'b0},
    '{OP_FRAME,     8'h00, 5'd8, 1'b0},
    '{OP_READ,      8'h00, 5'd0, 1'b0}
  };

  logic         clk;
  logic         i_rst_n;
  logic         i_enable;
  logic         i_reset_display;
  logic         i_data_command_mode;
  logic         i_enable_tearing;
  logic         i_chip_select;
  pixel_count_t i_num_pixels;
  logic         i_cmd_parameter;
  logic         i_cmd_write_stb;
  logic         i_cmd_read_stb;
  lcd_byte_t    i_cmd_data;
  lcd_byte_t    o_cmd_data;
  logic         o_cmd_finished;
  logic         i_pix_stb;
  pixel_t       i_pix_data;
  logic         o_pix_full;
  logic         o_frame_done;
  logic         o_register_data_sel;
  logic         o_write_n;
  logic         o_read_n;
  lcd_byte_t    i_data;
  lcd_byte_t    o_data;
  logic         o_cs_n;
  logic         o_reset_n;
  logic         i_tearing_effect;

  bus_byte_t    seen [$];
  bus_byte_t    low_byte;
  logic         wr_prev = 1'b1;

  lcd_ctrl_top dut0 (.*);

  always #HALF_PERIOD clk = ~clk;

  // Panel side, one entry per rising edge of the write strobe
  always @(negedge clk) begin
    if (o_write_n === 1'b0) begin
      low_byte.dc   = o_register_data_sel;
      low_byte.data = o_data;
    end else if (o_write_n === 1'b1 && wr_prev === 1'b0) begin
      seen.push_back(low_byte);
    end
    wr_prev = o_write_n;
  end

  task automatic check_byte(input string name, input lcd_byte_t got, input lcd_byte_t exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  task automatic check_count(input string name, input pixel_count_t got,
                             input pixel_count_t exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s within %0d cycles", what, TIMEOUT);
    $display("=== FAIL ===");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // One host strobe, then wait for the finished pulse
  task automatic run_cmd(input logic is_read, input logic param, input lcd_byte_t value,
                         output pixel_count_t cycles, output pixel_count_t read_low);
    cycles          = 0;
    read_low        = 0;
    i_cmd_parameter = param;
    i_cmd_data      = value;
    i_cmd_read_stb  = is_read;
    i_cmd_write_stb = !is_read;
    next_cycle();
    i_cmd_read_stb  = 1'b0;
    i_cmd_write_stb = 1'b0;
    cycles          = 1;
    while (o_cmd_finished !== 1'b1) begin
      if (o_read_n === 1'b0) begin
        read_low++;
      end
      if (cycles >= TIMEOUT) begin
        report_timeout("o_cmd_finished never pulsed");
      end
      next_cycle();
      cycles++;
    end
  endtask

  task automatic do_write(input logic param, input lcd_byte_t value);
    pixel_count_t cycles;
    pixel_count_t read_low;
    i_data_command_mode = 1'b0;
    i_enable            = 1'b1;
    run_cmd(1'b0, param, value, cycles, read_low);
    check_count("write cycles", cycles, 3);
    next_cycle();
    check_bit("o_cmd_finished", o_cmd_finished, 1'b0);
    check_count("bus bytes", seen.size(), 1);
    check_bit("o_register_data_sel", seen[0].dc, param);
    check_byte("o_data", seen[0].data, value);
  endtask

  task automatic do_read();
    pixel_count_t cycles;
    pixel_count_t read_low;
    lcd_byte_t    resp;
    resp                = lcd_byte_t'($urandom);
    i_data              = resp;
    i_data_command_mode = 1'b0;
    i_enable            = 1'b1;
    run_cmd(1'b1, 1'b0, 8'h00, cycles, read_low);
    check_count("read cycles", cycles, 4);
    check_count("o_read_n low cycles", read_low, 2);
    check_byte("o_cmd_data", o_cmd_data, resp);
    next_cycle();
    check_count("bus bytes", seen.size(), 0);
  endtask

  task automatic push_pixel(input pixel_t p);
    i_pix_stb  = 1'b1;
    i_pix_data = p;
    next_cycle();
    i_pix_stb  = 1'b0;
  endtask

  task automatic do_frame(input int count, input logic tearing, input logic gapped);
    pixel_t    pix [$];
    pixel_t    p;
    lcd_byte_t exp_b;
    int        cycles;
    int        idx;
    i_enable            = gapped;
    i_data_command_mode = 1'b1;
    i_enable_tearing    = tearing;
    i_num_pixels        = pixel_count_t'(count);
    for (int k = 0; k < count; k++) begin
      p = pixel_t'($urandom);
      pix.push_back(p);
      push_pixel(p);
      if (gapped && k < count - 1) begin
        repeat (GAP) next_cycle();
      end
    end
    if (!gapped) begin
      check_bit("o_pix_full", o_pix_full, count == FIFO_DEPTH);
      i_enable = 1'b1;
    end
    if (tearing) begin
      repeat (QUIET) next_cycle();
      check_count("bus bytes before tearing edge", seen.size(), 0);
      i_tearing_effect = 1'b1;
    end
    cycles = 0;
    while (o_frame_done !== 1'b1) begin
      if (cycles >= TIMEOUT) begin
        report_timeout("o_frame_done never pulsed");
      end
      next_cycle();
      cycles++;
    end
    i_tearing_effect = 1'b0;
    next_cycle();
    check_bit("o_frame_done", o_frame_done, 1'b0);
    check_count("bus bytes", seen.size(), 3 * count + 1);
    check_bit("o_register_data_sel", seen[0].dc, 1'b0);
    check_byte("o_data", seen[0].data, CMD_MEMORY_WRITE);
    // Red first, then green, then blue
    for (int k = 0; k < count; k++) begin
      for (int b = 0; b < 3; b++) begin
        idx   = 1 + 3 * k + b;
        exp_b = lcd_byte_t'(pix[k] >> (8 * (2 - b)));
        check_bit("o_register_data_sel", seen[idx].dc, 1'b1);
        check_byte("o_data", seen[idx].data, exp_b);
      end
    end
  endtask

  initial begin
    logic [31:0] seed_ret;
    row_t        row;
    seed_ret            = $urandom(SEED);
    clk                 = 1'b0;
    i_rst_n             = 1'b0;
    i_enable            = 1'b0;
    i_reset_display     = 1'b1;
    i_data_command_mode = 1'b0;
    i_enable_tearing    = 1'b0;
    i_chip_select       = 1'b0;
    i_num_pixels        = '0;
    i_cmd_parameter     = 1'b0;
    i_cmd_write_stb     = 1'b0;
    i_cmd_read_stb      = 1'b0;
    i_cmd_data          = '0;
    i_pix_stb           = 1'b0;
    i_pix_data          = '0;
    i_data              = '0;
    i_tearing_effect    = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    i_rst_n = 1'b1;
    next_cycle();
    check_bit("o_write_n", o_write_n, 1'b1);
    check_bit("o_read_n", o_read_n, 1'b1);
    check_bit("o_cs_n", o_cs_n, 1'b1);
    check_bit("o_reset_n", o_reset_n, 1'b0);
    check_bit("o_cmd_finished", o_cmd_finished, 1'b0);
    check_bit("o_frame_done", o_frame_done, 1'b0);
    check_bit("o_pix_full", o_pix_full, 1'b0);
    // Release the panel and select it
    i_reset_display = 1'b0;
    i_chip_select   = 1'b1;
    repeat (2) next_cycle();
    check_bit("o_reset_n", o_reset_n, 1'b1);
    check_bit("o_cs_n", o_cs_n, 1'b0);
    for (int i = 0; i < NUM_ROWS; i++) begin
      row = ROWS[i];
      seen.delete();
      case (row.op)
        OP_CMD:       do_write(1'b0, row.value);
        OP_PARAM:     do_write(1'b1, row.value);
        OP_READ:      do_read();
        OP_FRAME_GAP: do_frame(row.count, row.tearing, 1'b1);
        default:      do_frame(row.count, row.tearing, 1'b0);
      endcase
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/lcd_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_top (
  input  logic                  clk,
  input  logic                  i_rst_n,

  // Control
  input  logic                  i_enable,
  input  logic                  i_reset_display,
  input  logic                  i_data_command_mode,
  input  logic                  i_enable_tearing,
  input  logic                  i_chip_select,
  input  lcd_pkg::pixel_count_t i_num_pixels,

  // Command port
  input  logic                  i_cmd_parameter,
  input  logic                  i_cmd_write_stb,
  input  logic                  i_cmd_read_stb,
  input  lcd_pkg::lcd_byte_t    i_cmd_data,
  output lcd_pkg::lcd_byte_t    o_cmd_data,
  output logic                  o_cmd_finished,

  // Pixel stream
  input  logic                  i_pix_stb,
  input  lcd_pkg::pixel_t       i_pix_data,
  output logic                  o_pix_full,
  output logic                  o_frame_done,

  // Panel pads
  output logic                  o_register_data_sel,
  output logic                  o_write_n,
  output logic                  o_read_n,
  input  lcd_pkg::lcd_byte_t    i_data,
  output lcd_pkg::lcd_byte_t    o_data,
  output logic                  o_cs_n,
  output logic                  o_reset_n,
  input  logic                  i_tearing_effect
);
  import lcd_pkg::*;

  logic     fifo_pop;
  logic     fifo_empty;
  pixel_t   fifo_data;
  lcd_bus_t cmd_bus;
  lcd_bus_t pix_bus;

  lcd_pixel_fifo fifo0 (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_push      (i_pix_stb),
    .i_push_data (i_pix_data),
    .i_pop       (fifo_pop),
    .o_pop_data  (fifo_data),
    .o_full      (o_pix_full),
    .o_empty     (fifo_empty)
  );

  lcd_cmd_engine cmd0 (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_enable        (i_enable),
    .i_cmd_parameter (i_cmd_parameter),
    .i_cmd_write_stb (i_cmd_write_stb),
    .i_cmd_read_stb  (i_cmd_read_stb),
    .i_cmd_data      (i_cmd_data),
    .i_data_in       (i_data),
    .o_cmd_data      (o_cmd_data),
    .o_cmd_finished  (o_cmd_finished),
    .o_bus           (cmd_bus)
  );

  lcd_pixel_writer writer0 (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_enable         (i_enable),
    .i_enable_tearing (i_enable_tearing),
    .i_tearing_effect (i_tearing_effect),
    .i_num_pixels     (i_num_pixels),
    .i_fifo_empty     (fifo_empty),
    .i_fifo_data      (fifo_data),
    .o_fifo_pop       (fifo_pop),
    .o_bus            (pix_bus),
    .o_frame_done     (o_frame_done)
  );

  lcd_bus_port port0 (
    .clk                 (clk),
    .i_rst_n             (i_rst_n),
    .i_data_command_mode (i_data_command_mode),
    .i_reset_display     (i_reset_display),
    .i_chip_select       (i_chip_select),
    .i_cmd_bus           (cmd_bus),
    .i_pix_bus           (pix_bus),
    .o_register_data_sel (o_register_data_sel),
    .o_write_n           (o_write_n),
    .o_read_n            (o_read_n),
    .o_data              (o_data),
    .o_cs_n              (o_cs_n),
    .o_reset_n           (o_reset_n)
  );

endmodule

`default_nettype wire

// ==== hw/lcd_bus_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_port (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_data_command_mode,
  input  logic               i_reset_display,
  input  logic               i_chip_select,
  input  lcd_pkg::lcd_bus_t  i_cmd_bus,
  input  lcd_pkg::lcd_bus_t  i_pix_bus,
  output logic               o_register_data_sel,
  output logic               o_write_n,
  output logic               o_read_n,
  output lcd_pkg::lcd_byte_t o_data,
  output logic               o_cs_n,
  output logic               o_reset_n
);
  import lcd_pkg::*;

  lcd_bus_t sel;

  // Mode 1 hands the bus to the pixel writer
  assign sel = i_data_command_mode ? i_pix_bus : i_cmd_bus;

  // Pads come straight from flops
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_register_data_sel <= 1'b1;
      o_write_n           <= 1'b1;
      o_read_n            <= 1'b1;
      o_cs_n              <= 1'b1;
      // Panel stays in reset until the host releases it
      o_reset_n           <= 1'b0;
    end else begin
      o_register_data_sel <= sel.dc;
      o_write_n           <= ~sel.wr;
      o_read_n            <= ~sel.rd;
      o_cs_n              <= ~i_chip_select;
      o_reset_n           <= ~i_reset_display;
    end
  end

  always_ff @(posedge clk) begin
    o_data <= sel.data;
  end

endmodule

`default_nettype wire

// ==== hw/lcd_pixel_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_pixel_writer (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_enable,
  input  logic                  i_enable_tearing,
  input  logic                  i_tearing_effect,
  input  lcd_pkg::pixel_count_t i_num_pixels,
  input  logic                  i_fifo_empty,
  input  lcd_pkg::pixel_t       i_fifo_data,
  output logic                  o_fifo_pop,
  output lcd_pkg::lcd_bus_t     o_bus,
  output logic                  o_frame_done
);
  import lcd_pkg::*;

  writer_state_e state;
  pixel_count_t  pix_cnt;
  logic [1:0]    byte_idx;
  logic          te_prev;
  pixel_t        pix_q;
  logic          te_rise;
  logic          frame_end;
  lcd_byte_t     pix_byte;

  assign te_rise   = i_tearing_effect && !te_prev;
  assign frame_end = (pix_cnt == i_num_pixels);

  // Pop as the next pixel's first byte starts
  assign o_fifo_pop = (state == NEXT) && !frame_end && !i_fifo_empty;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state        <= PIX_IDLE;
      pix_cnt      <= '0;
      byte_idx     <= 2'd0;
      te_prev      <= 1'b0;
      o_frame_done <= 1'b0;
    end else begin
      te_prev      <= i_tearing_effect;
      o_frame_done <= 1'b0;
      case (state)
        PIX_IDLE: begin
          pix_cnt  <= '0;
          byte_idx <= 2'd0;
          if (i_enable && !i_fifo_empty) begin
            state <= i_enable_tearing ? WAIT_TE : CMD_LOW;
          end
        end
        WAIT_TE: begin
          if (!i_enable) begin
            state <= PIX_IDLE;
          end else if (te_rise) begin
            state <= CMD_LOW;
          end
        end
        CMD_LOW:  state <= CMD_HIGH;
        CMD_HIGH: state <= NEXT;
        PIX_LOW:  state <= PIX_HIGH;
        PIX_HIGH: begin
          if (byte_idx == 2'd2) begin
            byte_idx <= 2'd0;
            pix_cnt  <= pix_cnt + 24'd1;
            state    <= NEXT;
          end else begin
            byte_idx <= byte_idx + 2'd1;
            state    <= PIX_LOW;
          end
        end
        // Waits here while the buffer runs dry
        NEXT: begin
          if (frame_end) begin
            o_frame_done <= 1'b1;
            state        <= PIX_IDLE;
          end else if (o_fifo_pop) begin
            state <= PIX_LOW;
          end
        end
        default: state <= PIX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (o_fifo_pop) begin
      pix_q <= i_fifo_data;
    end
  end

  // R, G, B order
  always_comb begin
    case (byte_idx)
      2'd0:    pix_byte = pix_q[23:16];
      2'd1:    pix_byte = pix_q[15:8];
      default: pix_byte = pix_q[7:0];
    endcase
  end

  always_comb begin
    o_bus.dc   = 1'b1;
    o_bus.wr   = 1'b0;
    o_bus.rd   = 1'b0;
    o_bus.data = '0;
    case (state)
      CMD_LOW: begin
        o_bus.dc   = 1'b0;
        o_bus.wr   = 1'b1;
        o_bus.data = CMD_MEMORY_WRITE;
      end
      CMD_HIGH: begin
        o_bus.dc   = 1'b0;
        o_bus.data = CMD_MEMORY_WRITE;
      end
      PIX_LOW: begin
        o_bus.wr   = 1'b1;
        o_bus.data = pix_byte;
      end
      PIX_HIGH: o_bus.data = pix_byte;
      default:  o_bus.data = '0;
    endcase
  end

  a_pop_not_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_fifo_pop |-> !i_fifo_empty);

endmodule

`default_nettype wire

// ==== hw/lcd_cmd_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_cmd_engine (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_enable,
  input  logic               i_cmd_parameter,
  input  logic               i_cmd_write_stb,
  input  logic               i_cmd_read_stb,
  input  lcd_pkg::lcd_byte_t i_cmd_data,
  input  lcd_pkg::lcd_byte_t i_data_in,
  output lcd_pkg::lcd_byte_t o_cmd_data,
  output logic               o_cmd_finished,
  output lcd_pkg::lcd_bus_t  o_bus
);
  import lcd_pkg::*;

  cmd_state_e state;
  logic       is_read;
  logic       dc_q;
  lcd_byte_t  data_q;
  logic       start;

  // Strobes only count while idle
  assign start = (state == CMD_IDLE) && i_enable && (i_cmd_write_stb || i_cmd_read_stb);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state   <= CMD_IDLE;
      is_read <= 1'b0;
      dc_q    <= 1'b0;
      data_q  <= '0;
    end else begin
      if (start) begin
        dc_q   <= i_cmd_parameter;
        data_q <= i_cmd_data;
      end
      case (state)
        CMD_IDLE: begin
          if (i_enable && i_cmd_write_stb) begin
            state   <= WR_LOW;
            is_read <= 1'b0;
          end else if (i_enable && i_cmd_read_stb) begin
            state   <= RD_LOW1;
            is_read <= 1'b1;
          end
        end
        WR_LOW:  state <= WR_HIGH;
        // Recovery cycle, a read also samples the pad here
        WR_HIGH: state <= DONE;
        RD_LOW1: state <= RD_LOW2;
        RD_LOW2: state <= WR_HIGH;
        DONE:    state <= CMD_IDLE;
        default: state <= CMD_IDLE;
      endcase
    end
  end

  // Pad read strobe lags one cycle behind rd, so its last low cycle is WR_HIGH
  always_ff @(posedge clk) begin
    if (state == WR_HIGH && is_read) begin
      o_cmd_data <= i_data_in;
    end
  end

  always_comb begin
    o_bus.dc   = dc_q;
    o_bus.wr   = (state == WR_LOW);
    o_bus.rd   = (state == RD_LOW1) || (state == RD_LOW2);
    o_bus.data = data_q;
  end

  assign o_cmd_finished = (state == DONE);

  a_wr_rd_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(o_bus.wr && o_bus.rd));

endmodule

`default_nettype wire

// ==== hw/lcd_pixel_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_pixel_fifo (
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic            i_push,
  input  lcd_pkg::pixel_t i_push_data,
  input  logic            i_pop,
  output lcd_pkg::pixel_t o_pop_data,
  output logic            o_full,
  output logic            o_empty
);
  import lcd_pkg::*;

  pixel_t             mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;

  // Pointers wrap on their own at the power of two depth
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_push_data;
    end
  end

  // Head of the buffer, valid in the cycle the writer pops it
  assign o_pop_data = mem[rd_ptr];
  assign o_full     = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign o_empty    = (count == '0);

  // Host must respect the full level
  a_no_push_full: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_push |-> !o_full);

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_pop |-> !o_empty);

endmodule

`default_nettype wire

// ==== hw/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

  // One byte on the 8080 bus
  typedef logic [7:0]  lcd_byte_t;

  // Red in the top byte, sent first
  typedef logic [23:0] pixel_t;

  typedef logic [23:0] pixel_count_t;

  // Drive from one engine toward the pads, active high inside the design
  typedef struct packed {
    logic      dc;    // 1 data or parameter, 0 command
    logic      wr;
    logic      rd;
    lcd_byte_t data;
  } lcd_bus_t;

  // IDLE is prefixed per machine so both enums can share this package
  typedef enum logic [2:0] {
    CMD_IDLE,
    WR_LOW,
    WR_HIGH,
    RD_LOW1,
    RD_LOW2,
    DONE
  } cmd_state_e;

  typedef enum logic [2:0] {
    PIX_IDLE,
    WAIT_TE,
    CMD_LOW,
    CMD_HIGH,
    PIX_LOW,
    PIX_HIGH,
    NEXT
  } writer_state_e;

  localparam int        FIFO_DEPTH       = 8;
  localparam int        FIFO_AW          = 3;
  localparam lcd_byte_t CMD_MEMORY_WRITE = 8'h2C;

endpackage

`default_nettype wire
